/* Makefile */
SRCS := $(shell grep -v '^+' sfu.f)

all: run

obj_dir/Vsfu_tb: sfu.f $(SRCS) include/sfu_macros.svh
	verilator --binary --timing --assert --top-module sfu_tb -f sfu.f -o Vsfu_tb

run: obj_dir/Vsfu_tb
	./obj_dir/Vsfu_tb +verilator+error+limit+100 | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* hw/sfu_csr_unit.sv */
`timescale 1ns/1ps
`include "sfu_macros.svh"

module sfu_csr_unit #(
    parameter int core_id = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         req_valid,
    input  sfu_pkg::sfu_op_e             req_op,
    input  logic [`SFU_NW_W-1:0]         req_wid,
    input  logic [`SFU_NUM_LANES-1:0]    req_tmask,
    input  logic [`SFU_NR_W-1:0]         req_rd,
    input  logic [`SFU_XLEN-1:0]         req_rs1_data,
    input  logic [`SFU_CSR_ADDR_W-1:0]   req_imm,
    output logic                         req_ready,

    output logic                         rsp_valid,
    output logic [`SFU_NW_W-1:0]         rsp_wid,
    output logic [`SFU_NUM_LANES-1:0]    rsp_tmask,
    output logic [`SFU_NR_W-1:0]         rsp_rd,
    output logic                         rsp_wb,
    output logic [`SFU_XLEN-1:0]         rsp_data,
    input  logic                         rsp_ready
);

    logic [`SFU_XLEN-1:0] scratch0 [`SFU_NUM_WARPS];
    logic [`SFU_XLEN-1:0] scratch1 [`SFU_NUM_WARPS];

    logic                 req_fire;
    logic [`SFU_XLEN-1:0] csr_old;
    logic [`SFU_XLEN-1:0] csr_new;
    logic                 wr_scratch0;
    logic                 wr_scratch1;

    // Slot accepts when empty or draining this cycle
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    // Old value of the addressed CSR
    always_comb begin
        case (req_imm)
            `SFU_CSR_SCRATCH0: csr_old = scratch0[req_wid];
            `SFU_CSR_SCRATCH1: csr_old = scratch1[req_wid];
            `SFU_CSR_WARP_ID:  csr_old = {{(`SFU_XLEN-`SFU_NW_W){1'b0}}, req_wid};
            `SFU_CSR_CORE_ID:  csr_old = core_id;
            default:           csr_old = '0;
        endcase
    end

    // Write rule per opcode
    always_comb begin
        case (req_op)
            sfu_pkg::OP_CSRRS: csr_new = csr_old | req_rs1_data;
            sfu_pkg::OP_CSRRC: csr_new = csr_old & ~req_rs1_data;
            default:           csr_new = req_rs1_data;
        endcase
    end

    // Only the scratch pair is writable
    assign wr_scratch0 = req_fire && (req_imm == `SFU_CSR_SCRATCH0);
    assign wr_scratch1 = req_fire && (req_imm == `SFU_CSR_SCRATCH1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < `SFU_NUM_WARPS; w++) begin
                scratch0[w] <= '0;
                scratch1[w] <= '0;
            end
        end else begin
            if (wr_scratch0) begin
                scratch0[req_wid] <= csr_new;
            end
            if (wr_scratch1) begin
                scratch1[req_wid] <= csr_new;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_ready) begin
            rsp_valid <= req_valid;
        end
    end

    // Response payload, held until the arbiter takes it
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_wid   <= req_wid;
            rsp_tmask <= req_tmask;
            rsp_rd    <= req_rd;
            rsp_data  <= csr_old;
        end
    end

    // CSR reads always write back
    assign rsp_wb = 1'b1;

endmodule

/* hw/sfu_pkg.sv */
package sfu_pkg;

    // Issue opcodes, CSR group first
    typedef enum logic [2:0] {
        OP_CSRRW  = 3'd0,
        OP_CSRRS  = 3'd1,
        OP_CSRRC  = 3'd2,
        OP_TMC    = 3'd3,
        OP_WSPAWN = 3'd4,
        OP_BAR    = 3'd5
    } sfu_op_e;

    // Tag on the warp control port
    typedef enum logic [1:0] {
        WCTL_TMC   = 2'd0,
        WCTL_SPAWN = 2'd1,
        WCTL_BAR   = 2'd2
    } wctl_kind_e;

endpackage

/* hw/sfu_rsp_arb.sv */
`timescale 1ns/1ps
`include "sfu_macros.svh"

module sfu_rsp_arb (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         csr_rsp_valid,
    input  logic [`SFU_NW_W-1:0]         csr_rsp_wid,
    input  logic [`SFU_NUM_LANES-1:0]    csr_rsp_tmask,
    input  logic [`SFU_NR_W-1:0]         csr_rsp_rd,
    input  logic                         csr_rsp_wb,
    input  logic [`SFU_XLEN-1:0]         csr_rsp_data,
    output logic                         csr_rsp_ready,

    input  logic                         wctl_rsp_valid,
    input  logic [`SFU_NW_W-1:0]         wctl_rsp_wid,
    input  logic [`SFU_NUM_LANES-1:0]    wctl_rsp_tmask,
    input  logic [`SFU_NR_W-1:0]         wctl_rsp_rd,
    input  logic                         wctl_rsp_wb,
    input  logic [`SFU_XLEN-1:0]         wctl_rsp_data,
    output logic                         wctl_rsp_ready,

    output logic                         rsp_valid,
    output logic [`SFU_NW_W-1:0]         rsp_wid,
    output logic [`SFU_NUM_LANES-1:0]    rsp_tmask,
    output logic [`SFU_NR_W-1:0]         rsp_rd,
    output logic                         rsp_wb,
    output logic [`SFU_XLEN-1:0]         rsp_data,
    input  logic                         rsp_ready
);

    logic last_wctl;
    logic load;
    logic sel_wctl;
    logic any_valid;

    assign load      = !rsp_valid || rsp_ready;
    assign any_valid = csr_rsp_valid || wctl_rsp_valid;

    // Round robin, CSR side wins a tie right after reset
    assign sel_wctl = wctl_rsp_valid && (!csr_rsp_valid || !last_wctl);

    assign csr_rsp_ready  = load && !sel_wctl;
    assign wctl_rsp_ready = load && sel_wctl;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_wctl <= 1'b1;
            rsp_valid <= 1'b0;
        end else if (load) begin
            rsp_valid <= any_valid;
            if (any_valid) begin
                last_wctl <= sel_wctl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && any_valid) begin
            rsp_wid   <= sel_wctl ? wctl_rsp_wid   : csr_rsp_wid;
            rsp_tmask <= sel_wctl ? wctl_rsp_tmask : csr_rsp_tmask;
            rsp_rd    <= sel_wctl ? wctl_rsp_rd    : csr_rsp_rd;
            rsp_wb    <= sel_wctl ? wctl_rsp_wb    : csr_rsp_wb;
            rsp_data  <= sel_wctl ? wctl_rsp_data  : csr_rsp_data;
        end
    end

endmodule

/* hw/sfu_unit.sv */
`timescale 1ns/1ps
`include "sfu_macros.svh"

module sfu_unit #(
    parameter int core_id = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         req_valid,
    input  sfu_pkg::sfu_op_e             req_op,
    input  logic [`SFU_NW_W-1:0]         req_wid,
    input  logic [`SFU_NUM_LANES-1:0]    req_tmask,
    input  logic [`SFU_NR_W-1:0]         req_rd,
    input  logic [`SFU_XLEN-1:0]         req_rs1_data,
    input  logic [`SFU_CSR_ADDR_W-1:0]   req_imm,
    output logic                         req_ready,

    output logic                         rsp_valid,
    output logic [`SFU_NW_W-1:0]         rsp_wid,
    output logic [`SFU_NUM_LANES-1:0]    rsp_tmask,
    output logic [`SFU_NR_W-1:0]         rsp_rd,
    output logic                         rsp_wb,
    output logic [`SFU_XLEN-1:0]         rsp_data,
    input  logic                         rsp_ready,

    output logic                         warp_ctl_valid,
    output sfu_pkg::wctl_kind_e          warp_ctl_kind,
    output logic [`SFU_NW_W-1:0]         warp_ctl_wid,
    output logic [`SFU_NUM_LANES-1:0]    warp_ctl_tmask,
    output logic [`SFU_NUM_WARPS-1:0]    warp_ctl_spawn_mask,
    output logic [`SFU_NUM_WARPS-1:0]    warp_ctl_release_mask
);

    logic is_csr;
    logic csr_req_valid, csr_req_ready;
    logic wctl_req_valid, wctl_req_ready;

    logic                      csr_rsp_valid, csr_rsp_ready, csr_rsp_wb;
    logic [`SFU_NW_W-1:0]      csr_rsp_wid;
    logic [`SFU_NUM_LANES-1:0] csr_rsp_tmask;
    logic [`SFU_NR_W-1:0]      csr_rsp_rd;
    logic [`SFU_XLEN-1:0]      csr_rsp_data;

    logic                      wctl_rsp_valid, wctl_rsp_ready, wctl_rsp_wb;
    logic [`SFU_NW_W-1:0]      wctl_rsp_wid;
    logic [`SFU_NUM_LANES-1:0] wctl_rsp_tmask;
    logic [`SFU_NR_W-1:0]      wctl_rsp_rd;
    logic [`SFU_XLEN-1:0]      wctl_rsp_data;

    // Opcode class decides the target unit
    assign is_csr = (req_op == sfu_pkg::OP_CSRRW) || (req_op == sfu_pkg::OP_CSRRS) ||
                    (req_op == sfu_pkg::OP_CSRRC);

    assign csr_req_valid  = req_valid && is_csr;
    assign wctl_req_valid = req_valid && !is_csr;
    assign req_ready      = is_csr ? csr_req_ready : wctl_req_ready;

    sfu_csr_unit #(.core_id(core_id)) u_csr_unit (
        .clk(clk), .rst_n(rst_n),
        .req_valid(csr_req_valid), .req_op(req_op), .req_wid(req_wid),
        .req_tmask(req_tmask), .req_rd(req_rd), .req_rs1_data(req_rs1_data),
        .req_imm(req_imm), .req_ready(csr_req_ready),
        .rsp_valid(csr_rsp_valid), .rsp_wid(csr_rsp_wid), .rsp_tmask(csr_rsp_tmask),
        .rsp_rd(csr_rsp_rd), .rsp_wb(csr_rsp_wb), .rsp_data(csr_rsp_data),
        .rsp_ready(csr_rsp_ready)
    );

    sfu_wctl_unit u_wctl_unit (
        .clk(clk), .rst_n(rst_n),
        .req_valid(wctl_req_valid), .req_op(req_op), .req_wid(req_wid),
        .req_tmask(req_tmask), .req_rd(req_rd), .req_rs1_data(req_rs1_data),
        .req_imm(req_imm), .req_ready(wctl_req_ready),
        .rsp_valid(wctl_rsp_valid), .rsp_wid(wctl_rsp_wid), .rsp_tmask(wctl_rsp_tmask),
        .rsp_rd(wctl_rsp_rd), .rsp_wb(wctl_rsp_wb), .rsp_data(wctl_rsp_data),
        .rsp_ready(wctl_rsp_ready),
        .warp_ctl_valid(warp_ctl_valid), .warp_ctl_kind(warp_ctl_kind),
        .warp_ctl_wid(warp_ctl_wid), .warp_ctl_tmask(warp_ctl_tmask),
        .warp_ctl_spawn_mask(warp_ctl_spawn_mask),
        .warp_ctl_release_mask(warp_ctl_release_mask)
    );

    // Commit merge with the output register
    sfu_rsp_arb u_rsp_arb (
        .clk(clk), .rst_n(rst_n),
        .csr_rsp_valid(csr_rsp_valid), .csr_rsp_wid(csr_rsp_wid),
        .csr_rsp_tmask(csr_rsp_tmask), .csr_rsp_rd(csr_rsp_rd), .csr_rsp_wb(csr_rsp_wb),
        .csr_rsp_data(csr_rsp_data), .csr_rsp_ready(csr_rsp_ready),
        .wctl_rsp_valid(wctl_rsp_valid), .wctl_rsp_wid(wctl_rsp_wid),
        .wctl_rsp_tmask(wctl_rsp_tmask), .wctl_rsp_rd(wctl_rsp_rd),
        .wctl_rsp_wb(wctl_rsp_wb), .wctl_rsp_data(wctl_rsp_data),
        .wctl_rsp_ready(wctl_rsp_ready),
        .rsp_valid(rsp_valid), .rsp_wid(rsp_wid), .rsp_tmask(rsp_tmask),
        .rsp_rd(rsp_rd), .rsp_wb(rsp_wb), .rsp_data(rsp_data), .rsp_ready(rsp_ready)
    );

endmodule

/* hw/sfu_wctl_unit.sv */
`timescale 1ns/1ps
`include "sfu_macros.svh"

module sfu_wctl_unit (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         req_valid,
    input  sfu_pkg::sfu_op_e             req_op,
    input  logic [`SFU_NW_W-1:0]         req_wid,
    input  logic [`SFU_NUM_LANES-1:0]    req_tmask,
    input  logic [`SFU_NR_W-1:0]         req_rd,
    input  logic [`SFU_XLEN-1:0]         req_rs1_data,
    input  logic [`SFU_CSR_ADDR_W-1:0]   req_imm,
    output logic                         req_ready,

    output logic                         rsp_valid,
    output logic [`SFU_NW_W-1:0]         rsp_wid,
    output logic [`SFU_NUM_LANES-1:0]    rsp_tmask,
    output logic [`SFU_NR_W-1:0]         rsp_rd,
    output logic                         rsp_wb,
    output logic [`SFU_XLEN-1:0]         rsp_data,
    input  logic                         rsp_ready,

    output logic                         warp_ctl_valid,
    output sfu_pkg::wctl_kind_e          warp_ctl_kind,
    output logic [`SFU_NW_W-1:0]         warp_ctl_wid,
    output logic [`SFU_NUM_LANES-1:0]    warp_ctl_tmask,
    output logic [`SFU_NUM_WARPS-1:0]    warp_ctl_spawn_mask,
    output logic [`SFU_NUM_WARPS-1:0]    warp_ctl_release_mask
);

    localparam int BAR_W = $clog2(`SFU_NUM_BARRIERS);

    logic [`SFU_NW_W:0]        bar_cnt  [`SFU_NUM_BARRIERS];
    logic [`SFU_NUM_WARPS-1:0] bar_mask [`SFU_NUM_BARRIERS];

    logic                      req_fire;
    logic                      is_bar;
    logic [BAR_W-1:0]          bar_id;
    logic [`SFU_NW_W:0]        bar_next_cnt;
    logic [`SFU_NUM_WARPS-1:0] wid_onehot;
    logic [`SFU_NUM_WARPS-1:0] bar_next_mask;
    logic                      bar_done;

    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    // Barrier arrival bookkeeping
    assign is_bar        = (req_op == sfu_pkg::OP_BAR);
    assign bar_id        = req_imm[BAR_W-1:0];
    assign bar_next_cnt  = bar_cnt[bar_id] + 1'b1;
    assign wid_onehot    = {{(`SFU_NUM_WARPS-1){1'b0}}, 1'b1} << req_wid;
    assign bar_next_mask = bar_mask[bar_id] | wid_onehot;
    assign bar_done      = is_bar &&
        ({{(`SFU_XLEN-`SFU_NW_W-1){1'b0}}, bar_next_cnt} == req_rs1_data);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < `SFU_NUM_BARRIERS; b++) begin
                bar_cnt[b]  <= '0;
                bar_mask[b] <= '0;
            end
        end else if (req_fire && is_bar) begin
            // Last arrival releases and re-arms the barrier
            bar_cnt[bar_id]  <= bar_done ? '0 : bar_next_cnt;
            bar_mask[bar_id] <= bar_done ? '0 : bar_next_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid      <= 1'b0;
            warp_ctl_valid <= 1'b0;
        end else begin
            if (req_ready) begin
                rsp_valid <= req_valid;
            end
            warp_ctl_valid <= req_fire && (!is_bar || bar_done);
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_wid   <= req_wid;
            rsp_tmask <= req_tmask;
            rsp_rd    <= req_rd;

            warp_ctl_wid          <= req_wid;
            warp_ctl_tmask        <= (req_op == sfu_pkg::OP_TMC) ?
                                     req_rs1_data[`SFU_NUM_LANES-1:0] : req_tmask;
            warp_ctl_spawn_mask   <= (req_op == sfu_pkg::OP_WSPAWN) ?
                                     req_rs1_data[`SFU_NUM_WARPS-1:0] : '0;
            warp_ctl_release_mask <= bar_done ? bar_next_mask : '0;
            case (req_op)
                sfu_pkg::OP_WSPAWN: warp_ctl_kind <= sfu_pkg::WCTL_SPAWN;
                sfu_pkg::OP_BAR:    warp_ctl_kind <= sfu_pkg::WCTL_BAR;
                default:            warp_ctl_kind <= sfu_pkg::WCTL_TMC;
            endcase
        end
    end

    // No register result for warp control
    assign rsp_wb   = 1'b0;
    assign rsp_data = '0;

endmodule

/* include/sfu_macros.svh */
`ifndef SFU_MACROS_SVH
`define SFU_MACROS_SVH

// Core geometry
`define SFU_NUM_WARPS    4
`define SFU_NUM_LANES    4
`define SFU_XLEN         32

// Warp id and destination register index widths
`define SFU_NW_W         2
`define SFU_NR_W         5

// Barrier ids per core
`define SFU_NUM_BARRIERS 2

// CSR address space
`define SFU_CSR_ADDR_W   12
`define SFU_CSR_SCRATCH0 12'h340
`define SFU_CSR_SCRATCH1 12'h341

// Read-only identification CSRs
`define SFU_CSR_WARP_ID  12'hCC1
`define SFU_CSR_CORE_ID  12'hCC2

`endif

/* sfu.f */
+incdir+include
hw/sfu_pkg.sv
hw/sfu_csr_unit.sv
hw/sfu_wctl_unit.sv
hw/sfu_rsp_arb.sv
hw/sfu_unit.sv
verification/sfu_sva.sv
verification/sfu_tb.sv

/* verification/sfu_sva.sv */
`timescale 1ns/1ps
`include "sfu_macros.svh"

module sfu_sva (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      req_valid,
    input sfu_pkg::sfu_op_e          req_op,
    input logic                      req_ready,
    input logic                      rsp_valid,
    input logic                      rsp_ready,
    input logic [`SFU_NW_W-1:0]      rsp_wid,
    input logic [`SFU_NUM_LANES-1:0] rsp_tmask,
    input logic [`SFU_NR_W-1:0]      rsp_rd,
    input logic                      rsp_wb,
    input logic [`SFU_XLEN-1:0]      rsp_data,
    input logic                      warp_ctl_valid
);

    int fail_count = 0;

    logic wctl_fire;

    assign wctl_fire = req_valid && req_ready && (req_op == sfu_pkg::OP_TMC ||
                       req_op == sfu_pkg::OP_WSPAWN || req_op == sfu_pkg::OP_BAR);

    // Stalled commit holds its payload
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid &&
        $stable({rsp_wid, rsp_tmask, rsp_rd, rsp_wb, rsp_data}))
        else begin
            $error("commit payload changed while stalled");
            fail_count++;
        end

    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !rsp_valid && !warp_ctl_valid)
        else begin
            $error("outputs active right after reset");
            fail_count++;
        end

    // One event pulse per accepted warp control request
    ctl_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        warp_ctl_valid |-> $past(wctl_fire))
        else begin
            $error("warp control pulse without an accepted request");
            fail_count++;
        end

    // A drained port frees the request side within a cycle
    ready_returns: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_ready && !req_ready |=> req_ready || !rsp_ready)
        else begin
            $error("request port stayed blocked while commits drained");
            fail_count++;
        end

endmodule

bind sfu_unit sfu_sva u_sfu_sva (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_op(req_op),
    .req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
    .rsp_wid(rsp_wid), .rsp_tmask(rsp_tmask), .rsp_rd(rsp_rd), .rsp_wb(rsp_wb),
    .rsp_data(rsp_data), .warp_ctl_valid(warp_ctl_valid)
);

/* verification/sfu_tb.sv */
`timescale 1ns/1ps
`include "sfu_macros.svh"

module sfu_tb;

    localparam int NUM_REQS = 400;
    localparam int TIMEOUT  = 200;

    typedef struct packed {
        logic [`SFU_NW_W-1:0]      wid;
        logic [`SFU_NUM_LANES-1:0] tmask;
        logic [`SFU_NR_W-1:0]      rd;
        logic [`SFU_XLEN-1:0]      data;
    } commit_t;

    typedef struct packed {
        sfu_pkg::wctl_kind_e       kind;
        logic [`SFU_NW_W-1:0]      wid;
        logic [`SFU_NUM_LANES-1:0] tmask;
        logic [`SFU_NUM_WARPS-1:0] spawn_mask;
        logic [`SFU_NUM_WARPS-1:0] release_mask;
    } event_t;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        req_valid;
    sfu_pkg::sfu_op_e            req_op;
    logic [`SFU_NW_W-1:0]        req_wid;
    logic [`SFU_NUM_LANES-1:0]   req_tmask;
    logic [`SFU_NR_W-1:0]        req_rd;
    logic [`SFU_XLEN-1:0]        req_rs1_data;
    logic [`SFU_CSR_ADDR_W-1:0]  req_imm;
    logic                        req_ready;
    logic                        rsp_valid;
    logic [`SFU_NW_W-1:0]        rsp_wid;
    logic [`SFU_NUM_LANES-1:0]   rsp_tmask;
    logic [`SFU_NR_W-1:0]        rsp_rd;
    logic                        rsp_wb;
    logic [`SFU_XLEN-1:0]        rsp_data;
    logic                        rsp_ready;
    logic                        warp_ctl_valid;
    sfu_pkg::wctl_kind_e         warp_ctl_kind;
    logic [`SFU_NW_W-1:0]        warp_ctl_wid;
    logic [`SFU_NUM_LANES-1:0]   warp_ctl_tmask;
    logic [`SFU_NUM_WARPS-1:0]   warp_ctl_spawn_mask;
    logic [`SFU_NUM_WARPS-1:0]   warp_ctl_release_mask;

    logic [15:0]               lfsr;
    logic                      fire_seen;
    logic [`SFU_XLEN-1:0]      scratch0_m [`SFU_NUM_WARPS];
    logic [`SFU_XLEN-1:0]      scratch1_m [`SFU_NUM_WARPS];
    int                        bar_cnt_m  [`SFU_NUM_BARRIERS];
    logic [`SFU_NUM_WARPS-1:0] bar_mask_m [`SFU_NUM_BARRIERS];
    commit_t                   csr_q[$];
    commit_t                   wctl_q[$];
    event_t                    event_q[$];
    int                        errors, checks, accepted, committed, events;

    sfu_unit u_sfu_unit (.*);

    always #4 clk = ~clk;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000);
        return b;
    endfunction

    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // CSR write rules: replace, set bits, clear bits
    function automatic logic [`SFU_XLEN-1:0] new_csr_value(sfu_pkg::sfu_op_e op,
            logic [`SFU_XLEN-1:0] old, logic [`SFU_XLEN-1:0] operand);
        case (op)
            sfu_pkg::OP_CSRRS: return old | operand;
            sfu_pkg::OP_CSRRC: return old & ~operand;
            default:           return operand;
        endcase
    endfunction

    task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("Error: %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        rsp_ready <= lfsr_bit();
    endtask

    task automatic drive_request();
        logic [31:0]      r;
        sfu_pkg::sfu_op_e op;
        r = lfsr_bits(3);
        case (r[2:0])
            3'd0:       op = sfu_pkg::OP_CSRRW;
            3'd1, 3'd6: op = sfu_pkg::OP_CSRRS;
            3'd2:       op = sfu_pkg::OP_CSRRC;
            3'd3:       op = sfu_pkg::OP_TMC;
            3'd4:       op = sfu_pkg::OP_WSPAWN;
            default:    op = sfu_pkg::OP_BAR;
        endcase
        req_valid <= 1'b1;
        req_op    <= op;
        r = lfsr_bits(`SFU_NW_W);
        req_wid <= r[`SFU_NW_W-1:0];
        r = lfsr_bits(`SFU_NUM_LANES);
        req_tmask <= r[`SFU_NUM_LANES-1:0];
        r = lfsr_bits(`SFU_NR_W);
        req_rd <= r[`SFU_NR_W-1:0];
        if (op == sfu_pkg::OP_TMC || op == sfu_pkg::OP_WSPAWN) begin
            // Upper operand bits must be ignored
            req_rs1_data <= lfsr_bits(8);
            req_imm      <= '0;
        end else if (op == sfu_pkg::OP_BAR) begin
            // Barrier 0 waits for 2 arrivals, barrier 1 for 3
            r = lfsr_bits(1);
            req_imm      <= {11'd0, r[0]};
            req_rs1_data <= r[0] ? 32'd3 : 32'd2;
        end else begin
            r = lfsr_bits(3);
            case (r[2:0])
                3'd0, 3'd1, 3'd2: req_imm <= `SFU_CSR_SCRATCH0;
                3'd3, 3'd4:       req_imm <= `SFU_CSR_SCRATCH1;
                3'd5:             req_imm <= `SFU_CSR_WARP_ID;
                3'd6:             req_imm <= `SFU_CSR_CORE_ID;
                default:          req_imm <= 12'h7A5;
            endcase
            req_rs1_data <= lfsr_bits(32);
        end
    endtask

    // Reference model, updated at the moment a request is accepted
    task automatic model_accept();
        commit_t c;
        event_t  e;
        int      b;
        c = '{wid: req_wid, tmask: req_tmask, rd: req_rd, data: '0};
        e = '{kind: sfu_pkg::WCTL_TMC, wid: req_wid, tmask: req_tmask,
              spawn_mask: '0, release_mask: '0};
        case (req_op)
            sfu_pkg::OP_CSRRW, sfu_pkg::OP_CSRRS, sfu_pkg::OP_CSRRC: begin
                case (req_imm)
                    `SFU_CSR_SCRATCH0: begin
                        c.data = scratch0_m[req_wid];
                        scratch0_m[req_wid] = new_csr_value(req_op, c.data, req_rs1_data);
                    end
                    `SFU_CSR_SCRATCH1: begin
                        c.data = scratch1_m[req_wid];
                        scratch1_m[req_wid] = new_csr_value(req_op, c.data, req_rs1_data);
                    end
                    `SFU_CSR_WARP_ID: c.data = {{(`SFU_XLEN-`SFU_NW_W){1'b0}}, req_wid};
                    default:          c.data = '0;
                endcase
                csr_q.push_back(c);
            end
            sfu_pkg::OP_TMC: begin
                e.tmask = req_rs1_data[`SFU_NUM_LANES-1:0];
                event_q.push_back(e);
                wctl_q.push_back(c);
            end
            sfu_pkg::OP_WSPAWN: begin
                e.kind       = sfu_pkg::WCTL_SPAWN;
                e.spawn_mask = req_rs1_data[`SFU_NUM_WARPS-1:0];
                event_q.push_back(e);
                wctl_q.push_back(c);
            end
            default: begin
                b = req_imm[0] ? 1 : 0;
                bar_cnt_m[b] = bar_cnt_m[b] + 1;
                bar_mask_m[b][req_wid] = 1'b1;
                if (bar_cnt_m[b] == int'(req_rs1_data)) begin
                    e.kind         = sfu_pkg::WCTL_BAR;
                    e.release_mask = bar_mask_m[b];
                    event_q.push_back(e);
                    bar_cnt_m[b]  = 0;
                    bar_mask_m[b] = '0;
                end
                wctl_q.push_back(c);
            end
        endcase
    endtask

    task automatic commit_seen();
        commit_t exp;
        committed++;
        if ((rsp_wb && csr_q.size() == 0) || (!rsp_wb && wctl_q.size() == 0)) begin
            errors++;
            $display("Commit arrived with no pending request of its kind (wb=%0d)", rsp_wb);
        end else begin
            exp = rsp_wb ? csr_q.pop_front() : wctl_q.pop_front();
            compare_value("commit wid", 32'(exp.wid), 32'(rsp_wid));
            compare_value("commit tmask", 32'(exp.tmask), 32'(rsp_tmask));
            compare_value("commit rd", 32'(exp.rd), 32'(rsp_rd));
            compare_value("commit data", exp.data, rsp_data);
        end
    endtask

    task automatic event_seen();
        event_t exp;
        events++;
        if (event_q.size() == 0) begin
            errors++;
            $display("Unexpected warp control event from warp %0d", warp_ctl_wid);
        end else begin
            exp = event_q.pop_front();
            compare_value("event kind", 32'(exp.kind), 32'(warp_ctl_kind));
            compare_value("event wid", 32'(exp.wid), 32'(warp_ctl_wid));
            case (exp.kind)
                sfu_pkg::WCTL_TMC:
                    compare_value("tmc tmask", 32'(exp.tmask), 32'(warp_ctl_tmask));
                sfu_pkg::WCTL_SPAWN:
                    compare_value("spawn mask", 32'(exp.spawn_mask), 32'(warp_ctl_spawn_mask));
                default:
                    compare_value("release mask", 32'(exp.release_mask),
                                  32'(warp_ctl_release_mask));
            endcase
        end
    endtask

    // Mid-cycle sampling, where DUT outputs have settled
    always @(negedge clk) begin
        fire_seen = rst_n && req_valid && req_ready;
        if (fire_seen) begin
            accepted++;
            model_accept();
        end
        if (rst_n && rsp_valid && rsp_ready) begin
            commit_seen();
        end
        if (rst_n && warp_ctl_valid) begin
            event_seen();
        end
    end

    initial begin
        int waited;
        lfsr = 16'd33302;
        {errors, checks, accepted, committed, events} = '0;
        fire_seen    = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_op       = sfu_pkg::OP_CSRRW;
        req_wid      = '0;
        req_tmask    = '0;
        req_rd       = '0;
        req_rs1_data = '0;
        req_imm      = '0;
        rsp_ready    = 1'b0;
        for (int w = 0; w < `SFU_NUM_WARPS; w++) begin
            scratch0_m[w] = '0;
            scratch1_m[w] = '0;
        end
        for (int b = 0; b < `SFU_NUM_BARRIERS; b++) begin
            bar_cnt_m[b]  = 0;
            bar_mask_m[b] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_value("reset rsp_valid", 32'd0, 32'(rsp_valid));
        compare_value("reset warp_ctl_valid", 32'd0, 32'(warp_ctl_valid));
        compare_value("reset req_ready", 32'd1, 32'(req_ready));
        next_cycle();
        for (int n = 0; n < NUM_REQS; n++) begin
            if (lfsr_bits(2) == 32'd0) begin
                req_valid <= 1'b0;
                next_cycle();
            end
            drive_request();
            waited = 0;
            next_cycle();
            while (!fire_seen && waited < TIMEOUT) begin
                waited++;
                next_cycle();
            end
            if (!fire_seen) begin
                errors++;
                $display("Timeout: request %0d was never accepted", n);
                break;
            end
        end
        req_valid <= 1'b0;
        rsp_ready <= 1'b1;
        waited = 0;
        while ((csr_q.size() != 0 || wctl_q.size() != 0) && waited < TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (csr_q.size() != 0 || wctl_q.size() != 0) begin
            errors++;
            $display("Timeout: %0d commits never arrived", csr_q.size() + wctl_q.size());
        end
        // Room for any stray extra commit or event
        repeat (4) @(posedge clk);
        compare_value("commit count", accepted, committed);
        if (event_q.size() != 0) begin
            errors++;
            $display("%0d expected warp control events never appeared", event_q.size());
        end
        $display("Requests %0d, commits %0d, events %0d, checks %0d, errors %0d, sva failures %0d",
                 accepted, committed, events, checks, errors, u_sfu_unit.u_sfu_sva.fail_count);
        if (errors == 0 && u_sfu_unit.u_sfu_sva.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
